/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := rv_core_tb
FILELIST  := rv_core.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator output is kept in a shell variable, the pass line decides
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* rv_core.f */
+incdir+verification
verilog/rv_isa_pkg.sv
verilog/core_ctrl_pkg.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/writeback_pc.sv
verilog/rv_core.sv
verification/rv_core_tb.sv

/* verification/rv_core_tests.svh */
`ifndef RV_CORE_TESTS_SVH
`define RV_CORE_TESTS_SVH

function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                input reg_idx_t rs1, input logic [2:0] f3,
                                input reg_idx_t rd);
    inst_t w;
    w.r_fmt.funct7 = f7;
    w.r_fmt.rs2    = rs2;
    w.r_fmt.rs1    = rs1;
    w.r_fmt.funct3 = f3;
    w.r_fmt.rd     = rd;
    w.r_fmt.opcode = OPC_OP;
    return w;
endfunction

function automatic word_t enc_i(input logic [2:0] f3, input reg_idx_t rd,
                                input reg_idx_t rs1, input logic [11:0] imm,
                                input opcode_t opc);
    inst_t w;
    w.i_fmt.imm_11_0 = imm;
    w.i_fmt.rs1      = rs1;
    w.i_fmt.funct3   = f3;
    w.i_fmt.rd       = rd;
    w.i_fmt.opcode   = opc;
    return w;
endfunction

// Word-sized SW only with funct3 fixed
function automatic word_t enc_s(input reg_idx_t rs2, input reg_idx_t rs1,
                                input logic [11:0] imm);
    inst_t w;
    w.s_fmt.imm_11_5 = imm[11:5];
    w.s_fmt.rs2      = rs2;
    w.s_fmt.rs1      = rs1;
    w.s_fmt.funct3   = 3'b010;
    w.s_fmt.imm_4_0  = imm[4:0];
    w.s_fmt.opcode   = OPC_STORE;
    return w;
endfunction

function automatic word_t enc_b(input logic [2:0] f3, input reg_idx_t rs1,
                                input reg_idx_t rs2, input logic [12:0] off);
    inst_t w;
    w.b_fmt.imm_12   = off[12];
    w.b_fmt.imm_10_5 = off[10:5];
    w.b_fmt.rs2      = rs2;
    w.b_fmt.rs1      = rs1;
    w.b_fmt.funct3   = f3;
    w.b_fmt.imm_4_1  = off[4:1];
    w.b_fmt.imm_11   = off[11];
    w.b_fmt.opcode   = OPC_BRANCH;
    return w;
endfunction

function automatic word_t enc_u(input opcode_t opc, input reg_idx_t rd,
                                input logic [19:0] imm);
    inst_t w;
    w.u_fmt.imm_31_12 = imm;
    w.u_fmt.rd        = rd;
    w.u_fmt.opcode    = opc;
    return w;
endfunction

function automatic word_t enc_j(input reg_idx_t rd, input logic [20:0] off);
    inst_t w;
    w.j_fmt.imm_20    = off[20];
    w.j_fmt.imm_10_1  = off[10:1];
    w.j_fmt.imm_11    = off[11];
    w.j_fmt.imm_19_12 = off[19:12];
    w.j_fmt.rd        = rd;
    w.j_fmt.opcode    = OPC_JAL;
    return w;
endfunction

// LUI rounds up so that the sign-extended ADDI lands on the value
task automatic load_const(input reg_idx_t rd, input word_t value);
    word_t upper;
    upper = value + 32'h0000_0800;
    emit(enc_u(OPC_LUI, rd, upper[31:12]));
    emit(enc_i(3'b000, rd, rd, value[11:0], OPC_OP_IMM));
endtask

function automatic word_t alu_expected(input logic [2:0] f3, input logic alt,
                                       input word_t a, input word_t b);
    case (f3)
        F3_ADD_SUB: return alt ? a - b : a + b;
        F3_SLL:     return a << b[4:0];
        F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
        F3_XOR:     return a ^ b;
        F3_SRL_SRA: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        F3_OR:      return a | b;
        default:    return a & b;
    endcase
endfunction

function automatic logic branch_expected(input logic [2:0] f3, input word_t a,
                                         input word_t b);
    case (f3)
        F3_BEQ:  return a == b;
        F3_BNE:  return a != b;
        F3_BLT:  return $signed(a) < $signed(b);
        F3_BGE:  return $signed(a) >= $signed(b);
        F3_BLTU: return a < b;
        default: return a >= b;
    endcase
endfunction

task automatic test_reset();
    int i;
    begin_program();
    // A store sits at the reset PC, so only the gate keeps dmem_we low
    emit(enc_s(5'd0, 5'd0, 12'h000));
    for (i = 0; i < 8; i++) begin
        @(posedge clk);
        #1;
        check_bit("dmem_we", dmem_we, 1'b0);
        check_pc(imem_addr, RESET_PC);
    end
    clear_dmem = 1'b0;
    rst_n = 1'b1;
    for (i = 0; i < 4; i++) begin
        check_pc(imem_addr, RESET_PC + word_t'(4 * i));
        step(1);
    end
endtask

task automatic test_alu();
    word_t      a;
    word_t      b;
    word_t      imm;
    logic [2:0] f3;
    logic       alt;
    int         k;
    word_t      exp_q [$];
    a = $random(seed);
    b = $random(seed);
    begin_program();
    load_const(5'd1, a);
    load_const(5'd2, b);
    // Register ops with SUB and SRA after the eight base variants
    for (k = 0; k < 10; k++) begin
        f3  = (k < 8) ? 3'(k) : ((k == 8) ? F3_ADD_SUB : F3_SRL_SRA);
        alt = (k >= 8);
        emit(enc_r(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
        emit(enc_s(5'd3, 5'd0, 12'(4 * k)));
        exp_q.push_back(alu_expected(f3, alt, a, b));
    end
    for (k = 0; k < 9; k++) begin
        f3  = (k < 8) ? 3'(k) : F3_SRL_SRA;
        alt = (k == 8);
        imm = $random(seed);
        if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
            imm[11:5] = alt ? 7'h20 : 7'h00;
        end
        emit(enc_i(f3, 5'd4, 5'd1, imm[11:0], OPC_OP_IMM));
        emit(enc_s(5'd4, 5'd0, 12'(40 + 4 * k)));
        exp_q.push_back(alu_expected(f3, alt, a, {{20{imm[11]}}, imm[11:0]}));
    end
    run_program(42);
    for (k = 0; k < exp_q.size(); k++) begin
        check_word($sformatf("dmem[%0d] alu result", k), dmem[8'(k)], exp_q[k]);
    end
endtask

task automatic test_upper_imm();
    logic [19:0] hi_lui;
    logic [19:0] hi_auipc;
    word_t       auipc_addr;
    hi_lui   = 20'($random(seed));
    hi_auipc = 20'($random(seed));
    begin_program();
    emit(enc_u(OPC_LUI, 5'd5, hi_lui));
    emit(enc_s(5'd5, 5'd0, 12'h030));
    auipc_addr = cur_addr();
    emit(enc_u(OPC_AUIPC, 5'd6, hi_auipc));
    emit(enc_s(5'd6, 5'd0, 12'h034));
    run_program(4);
    check_word("dmem[0x30] lui", dmem[8'h0c], {hi_lui, 12'h000});
    check_word("dmem[0x34] auipc", dmem[8'h0d], {hi_auipc, 12'h000} + auipc_addr);
endtask

// Not taken runs 0x111 then jumps over, taken lands on 0x222
task automatic branch_case(input logic [2:0] f3, input word_t a, input word_t b);
    word_t br_addr;
    word_t marker;
    logic  taken;
    taken  = branch_expected(f3, a, b);
    marker = taken ? 32'h0000_0222 : 32'h0000_0111;
    begin_program();
    load_const(5'd1, a);
    load_const(5'd2, b);
    br_addr = cur_addr();
    emit(enc_b(f3, 5'd1, 5'd2, 13'd12));
    emit(enc_i(3'b000, 5'd7, 5'd0, 12'h111, OPC_OP_IMM));
    emit(enc_j(5'd0, 21'd8));
    emit(enc_i(3'b000, 5'd7, 5'd0, 12'h222, OPC_OP_IMM));
    emit(enc_s(5'd7, 5'd0, 12'h040));
    run_program(4);
    check_pc(imem_addr, br_addr);
    step(1);
    check_pc(imem_addr, taken ? br_addr + 32'd12 : br_addr + 32'd4);
    step(3);
    check_word($sformatf("dmem[0x40] marker, funct3 %0d", f3), dmem[8'h10], marker);
endtask

task automatic test_branches();
    logic [2:0] f3s [6];
    word_t      neg;
    word_t      pos;
    int         k;
    f3s = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    neg = $random(seed);
    pos = $random(seed);
    neg[31] = 1'b1;
    pos[31] = 1'b0;
    for (k = 0; k < 6; k++) begin
        branch_case(f3s[k], pos, pos);
        branch_case(f3s[k], neg, pos);
        branch_case(f3s[k], pos, neg);
    end
endtask

task automatic test_jumps();
    begin_program();
    emit(enc_j(5'd1, 21'd12));
    emit(enc_i(3'b000, 5'd1, 5'd0, 12'h7ad, OPC_OP_IMM));
    emit(enc_i(3'b000, 5'd1, 5'd0, 12'h7ad, OPC_OP_IMM));
    emit(enc_s(5'd1, 5'd0, 12'h010));
    // Target drops bit 0 of the odd offset
    emit(enc_i(3'b000, 5'd2, 5'd1, 12'd25, OPC_JALR));
    emit(enc_i(3'b000, 5'd2, 5'd0, 12'h7ad, OPC_OP_IMM));
    emit(enc_i(3'b000, 5'd2, 5'd0, 12'h7ad, OPC_OP_IMM));
    emit(enc_s(5'd2, 5'd0, 12'h014));
    run_program(1);
    check_pc(imem_addr, RESET_PC + 32'd12);
    step(2);
    check_pc(imem_addr, RESET_PC + 32'd28);
    step(1);
    check_word("dmem[0x10] jal link", dmem[8'h04], RESET_PC + 32'd4);
    check_word("dmem[0x14] jalr link", dmem[8'h05], RESET_PC + 32'd20);
endtask

task automatic test_memory();
    word_t val;
    val = $random(seed);
    begin_program();
    load_const(5'd1, val);
    emit(enc_s(5'd1, 5'd0, 12'h020));
    emit(enc_i(3'b010, 5'd3, 5'd0, 12'h020, OPC_LOAD));
    emit(enc_s(5'd3, 5'd0, 12'h024));
    emit(enc_i(3'b000, 5'd0, 5'd1, 12'h000, OPC_OP_IMM));
    emit(enc_s(5'd0, 5'd0, 12'h028));
    emit(enc_u(OPC_LUI, 5'd0, 20'habcde));
    emit(enc_s(5'd0, 5'd0, 12'h02c));
    run_program(9);
    check_word("dmem[0x20] sw", dmem[8'h08], val);
    check_word("dmem[0x24] lw", dmem[8'h09], val);
    check_word("dmem[0x28] x0 after addi", dmem[8'h0a], 32'h0000_0000);
    check_word("dmem[0x2c] x0 after lui", dmem[8'h0b], 32'h0000_0000);
endtask

`endif

/* verification/rv_core_tb.sv */
`timescale 1ns/100ps

module rv_core_tb
    import rv_isa_pkg::*;
();

    localparam word_t RESET_PC = 32'h0000_0080;
    localparam word_t NOP      = 32'h0000_0013;

    // Cycles per program are 1 to enter reset, 8 in reset, then the run
    localparam int TEST_CYCLES = 13 + 51 + 13 + 18 * 17 + 13 + 18;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 50) * 10;

    logic   clk = 1'b0;
    logic   rst_n = 1'b0;
    logic   clear_dmem = 1'b1;
    integer seed = 32'h6264;

    word_t imem_addr;
    word_t imem_rdata;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    word_t dmem_rdata;

    word_t      imem [256];
    word_t      dmem [256];
    logic [7:0] wr_ptr;

    always #5 clk = ~clk;

    rv_core #(
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    // Both memories read combinationally at the word address
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    function automatic word_t fill_word(input logic [7:0] idx);
        return {8'hd0, idx, ~idx, idx ^ 8'h5a};
    endfunction

    // Data memory refilled at every edge while a new program loads
    initial begin
        int i;
        forever begin
            if (clear_dmem) begin
                for (i = 0; i < 256; i++) begin
                    dmem[8'(i)] <= fill_word(8'(i));
                end
            end else if (dmem_we) begin
                dmem[dmem_addr[9:2]] <= dmem_wdata;
            end
            @(posedge clk);
        end
    end

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic fail_now(input string what);
        $display("ERROR: %s", what);
        abort_run();
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pc(input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED imem_addr: got 0x%08h, expected 0x%08h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic clear_imem();
        int i;
        for (i = 0; i < 256; i++) begin
            imem[8'(i)] = NOP;
        end
        wr_ptr = RESET_PC[9:2];
    endtask

    task automatic emit(input word_t w);
        imem[wr_ptr] = w;
        wr_ptr = wr_ptr + 8'd1;
    endtask

    function automatic word_t cur_addr();
        return {22'b0, wr_ptr, 2'b00};
    endfunction

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Enters reset and empties both memories
    task automatic begin_program();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        clear_dmem = 1'b1;
        clear_imem();
    endtask

    task automatic run_program(input int n);
        repeat (8) @(posedge clk);
        #1;
        clear_dmem = 1'b0;
        rst_n = 1'b1;
        step(n);
    endtask

    `include "rv_core_tests.svh"

    initial begin
        #(WATCHDOG_NS);
        fail_now("watchdog expired before the test sequence finished");
    end

    initial begin
        clear_imem();
        test_reset();
        test_alu();
        test_upper_imm();
        test_branches();
        test_jumps();
        test_memory();
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* verilog/core_ctrl_pkg.sv */
package core_ctrl_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        OPA_RS1,
        OPA_PC,
        OPA_ZERO
    } op_a_sel_t;

    typedef enum logic {
        OPB_RS2,
        OPB_IMM
    } op_b_sel_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_t;

    // Branch is taken only when the compare holds
    typedef enum logic [1:0] {
        PC_PLUS4,
        PC_BRANCH,
        PC_JAL,
        PC_JALR
    } pc_sel_t;

    typedef struct packed {
        alu_op_t    alu_op;
        op_a_sel_t  op_a_sel;
        op_b_sel_t  op_b_sel;
        wb_sel_t    wb_sel;
        pc_sel_t    pc_sel;
        logic [2:0] br_funct3;
        logic       rf_we;
        logic       mem_we;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      imm;
    } ctrl_t;

endpackage

/* verilog/exec_unit.sv */
`timescale 1ns/100ps

module exec_unit
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  ctrl_t ctrl,
    input  word_t pc,
    input  word_t rs1_data,
    input  word_t rs2_data,
    output word_t alu_result,
    output logic  branch_taken,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_we,
    input  logic  rst_n,
    input  logic  clk
);

    word_t      op_a;
    word_t      op_b;
    word_t      sum;
    logic [4:0] shamt;
    logic       br_eq;
    logic       br_lt;
    logic       br_ltu;

    always_comb begin
        case (ctrl.op_a_sel)
            OPA_PC:   op_a = pc;
            OPA_ZERO: op_a = '0;
            default:  op_a = rs1_data;
        endcase
    end

    assign op_b  = (ctrl.op_b_sel == OPB_IMM) ? ctrl.imm : rs2_data;
    assign sum   = op_a + op_b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << shamt;
            ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> shamt;
            ALU_SRA:    alu_result = word_t'($signed(op_a) >>> shamt);
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = sum;
        endcase
    end

    // Branch compare works on the register values directly
    assign br_eq  = (rs1_data == rs2_data);
    assign br_lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign br_ltu = (rs1_data < rs2_data);

    always_comb begin
        case (ctrl.br_funct3)
            F3_BEQ:  branch_taken = br_eq;
            F3_BNE:  branch_taken = !br_eq;
            F3_BLT:  branch_taken = br_lt;
            F3_BGE:  branch_taken = !br_lt;
            F3_BLTU: branch_taken = br_ltu;
            F3_BGEU: branch_taken = !br_ltu;
            default: branch_taken = 1'b0;
        endcase
    end

    assign dmem_addr  = sum;
    assign dmem_wdata = rs2_data;
    assign dmem_we    = ctrl.mem_we && rst_n;

    store_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) dmem_we |-> (dmem_addr[1:0] == 2'b00)
    );

endmodule

/* verilog/inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  word_t inst,
    output ctrl_t ctrl
);

    inst_t iw;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign iw = inst_t'(inst);

    // Sign-extended immediates, one per format
    assign imm_i = {{20{iw.i_fmt.imm_11_0[11]}}, iw.i_fmt.imm_11_0};
    assign imm_s = {{20{iw.s_fmt.imm_11_5[6]}}, iw.s_fmt.imm_11_5, iw.s_fmt.imm_4_0};
    assign imm_b = {{19{iw.b_fmt.imm_12}}, iw.b_fmt.imm_12, iw.b_fmt.imm_11,
                    iw.b_fmt.imm_10_5, iw.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {iw.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{11{iw.j_fmt.imm_20}}, iw.j_fmt.imm_20, iw.j_fmt.imm_19_12,
                    iw.j_fmt.imm_11, iw.j_fmt.imm_10_1, 1'b0};

    // Bit 30 picks SUB only for register ops, SRA for both
    function automatic alu_op_t alu_from_funct(input logic [2:0] funct3,
                                               input logic bit30,
                                               input logic is_reg);
        alu_op_t op;
        case (funct3)
            F3_ADD_SUB: op = (is_reg && bit30) ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = bit30 ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl.alu_op    = ALU_ADD;
        ctrl.op_a_sel  = OPA_RS1;
        ctrl.op_b_sel  = OPB_IMM;
        ctrl.wb_sel    = WB_ALU;
        ctrl.pc_sel    = PC_PLUS4;
        ctrl.br_funct3 = iw.r_fmt.funct3;
        ctrl.rf_we     = 1'b0;
        ctrl.mem_we    = 1'b0;
        ctrl.rd        = iw.r_fmt.rd;
        ctrl.rs1       = iw.r_fmt.rs1;
        ctrl.rs2       = iw.r_fmt.rs2;
        ctrl.imm       = imm_i;

        case (iw.r_fmt.opcode)
            OPC_OP: begin
                ctrl.alu_op   = alu_from_funct(iw.r_fmt.funct3, iw.r_fmt.funct7[5], 1'b1);
                ctrl.op_b_sel = OPB_RS2;
                ctrl.rf_we    = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.alu_op = alu_from_funct(iw.i_fmt.funct3, iw.r_fmt.funct7[5], 1'b0);
                ctrl.rf_we  = 1'b1;
            end
            OPC_LUI: begin
                ctrl.alu_op   = ALU_PASS_B;
                ctrl.op_a_sel = OPA_ZERO;
                ctrl.imm      = imm_u;
                ctrl.rf_we    = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.op_a_sel = OPA_PC;
                ctrl.imm      = imm_u;
                ctrl.rf_we    = 1'b1;
            end
            OPC_JAL: begin
                ctrl.wb_sel = WB_PC4;
                ctrl.pc_sel = PC_JAL;
                ctrl.imm    = imm_j;
                ctrl.rf_we  = 1'b1;
            end
            OPC_JALR: begin
                ctrl.wb_sel = WB_PC4;
                ctrl.pc_sel = PC_JALR;
                ctrl.rf_we  = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.op_b_sel = OPB_RS2;
                ctrl.pc_sel   = PC_BRANCH;
                ctrl.imm      = imm_b;
            end
            // Every load width is treated as LW
            OPC_LOAD: begin
                ctrl.wb_sel = WB_MEM;
                ctrl.rf_we  = 1'b1;
            end
            OPC_STORE: begin
                ctrl.imm    = imm_s;
                ctrl.mem_we = 1'b1;
            end
            default: begin
                ctrl.rf_we  = 1'b0;
                ctrl.mem_we = 1'b0;
            end
        endcase
    end

    // No opcode both writes a register and stores
    we_exclusive: assert property (@(inst) !(ctrl.rf_we && ctrl.mem_we));

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/100ps

module reg_file
    import rv_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     we,
    input  reg_idx_t rd,
    input  word_t    rd_data
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst_n && we && (rd != '0)) begin
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // A write aimed at x0 must not show up on the next read
    x0_stays_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (we && (rd == '0)) |=> ((rs1 != '0) || (rs1_data == '0))
    );

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/100ps

module rv_core
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  rst_n,
    output word_t imem_addr,
    input  word_t imem_rdata,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_we,
    input  word_t dmem_rdata
);

    ctrl_t ctrl;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_result;
    logic  branch_taken;
    word_t rd_data;
    logic  rf_we;

    inst_decoder u_decoder (
        .inst (imem_rdata),
        .ctrl (ctrl)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .rd       (ctrl.rd),
        .rd_data  (rd_data)
    );

    // The PC doubles as the fetch address
    exec_unit u_exec (
        .ctrl         (ctrl),
        .pc           (imem_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_we      (dmem_we),
        .rst_n        (rst_n),
        .clk          (clk)
    );

    writeback_pc #(
        .RESET_PC (RESET_PC)
    ) u_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .dmem_rdata   (dmem_rdata),
        .pc           (imem_addr),
        .rd_data      (rd_data),
        .rf_we        (rf_we)
    );

endmodule

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_t;

    // Branch compares
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ALU variants, shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        opcode_t    opcode;
    } j_fmt_t;

    // One instruction word, seen through each encoding format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_t;

endpackage

/* verilog/writeback_pc.sv */
`timescale 1ns/100ps

module writeback_pc
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  rst_n,
    input  ctrl_t ctrl,
    input  word_t alu_result,
    input  logic  branch_taken,
    input  word_t dmem_rdata,
    output word_t pc,
    output word_t rd_data,
    output logic  rf_we
);

    word_t pc_plus4;
    word_t pc_target;
    word_t next_pc;

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + ctrl.imm;

    always_comb begin
        case (ctrl.pc_sel)
            PC_BRANCH: next_pc = branch_taken ? pc_target : pc_plus4;
            PC_JAL:    next_pc = pc_target;
            PC_JALR:   next_pc = {alu_result[31:1], 1'b0};
            default:   next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  rd_data = dmem_rdata;
            WB_PC4:  rd_data = pc_plus4;
            default: rd_data = alu_result;
        endcase
    end

    assign rf_we = ctrl.rf_we && rst_n;

    // Holds as long as every jump target is word-aligned
    pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) rst_n |=> (pc[1:0] == 2'b00)
    );

endmodule
